// ==== Bender.yml ====
package:
  name: mmu_xlat

dependencies: {}

sources:
  - logic/mmu_pkg.sv
  - logic/mmu_csr_apb.sv
  - logic/xlat_decode.sv
  - logic/tlb_array.sv
  - logic/xlat_result.sv
  - logic/mmu_top.sv
  - target: test
    files:
      - verification/mmu_tb.sv

// ==== list.f ====
logic/mmu_pkg.sv
logic/mmu_csr_apb.sv
logic/xlat_decode.sv
logic/tlb_array.sv
logic/xlat_result.sv
logic/mmu_top.sv
verification/mmu_tb.sv

// ==== logic/mmu_csr_apb.sv ====
`timescale 1ns/10ps

module mmu_csr_apb (
    input  logic              clk,
    input  logic              rst_n,
    input  mmu_pkg::apb_req_t apb_req,
    output mmu_pkg::apb_rsp_t apb_rsp,
    output mmu_pkg::mmu_cfg_t cfg,
    output mmu_pkg::tlb_wr_t  tlb_wr
);
    import mmu_pkg::*;

    logic [31:0] crmd_q;
    logic [31:0] asid_q;
    logic [31:0] dmw0_q;
    logic [31:0] dmw1_q;
    logic [31:0] tlbehi_q;
    logic [31:0] tlbelo0_q;
    logic [31:0] tlbelo1_q;
    logic [31:0] tlbidx_q;

    logic        access;
    logic        addr_ok;
    logic        wr_en;
    logic        cmd_wr;
    logic [31:0] rdata;
    tlb_entry_t  staged;
    logic        wr_we_q;
    tlb_idx_t    wr_idx_q;
    tlb_entry_t  wr_entry_q;

    // one TLBELO word unpacked into a page
    function automatic tlb_page_t elo_page(input logic [31:0] elo);
        tlb_page_t p;
        p.ppn = elo[27:8];
        p.plv = elo[3:2];
        p.mat = elo[5:4];
        p.d   = elo[1];
        p.v   = elo[0];
        return p;
    endfunction

    assign access  = apb_req.psel & apb_req.penable;
    assign addr_ok = (apb_req.paddr[1:0] == 2'b00) && (apb_req.paddr <= REG_TLBCMD);
    assign wr_en   = access & apb_req.pwrite & addr_ok;
    assign cmd_wr  = wr_en && (apb_req.paddr == REG_TLBCMD);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            crmd_q    <= CRMD_RESET;
            asid_q    <= '0;
            dmw0_q    <= '0;
            dmw1_q    <= '0;
            tlbehi_q  <= '0;
            tlbelo0_q <= '0;
            tlbelo1_q <= '0;
            tlbidx_q  <= '0;
        end else if (wr_en) begin
            case (apb_req.paddr)
                REG_CRMD:    crmd_q    <= apb_req.pwdata & CRMD_MASK;
                REG_ASID:    asid_q    <= apb_req.pwdata & ASID_MASK;
                REG_DMW0:    dmw0_q    <= apb_req.pwdata & DMW_MASK;
                REG_DMW1:    dmw1_q    <= apb_req.pwdata & DMW_MASK;
                REG_TLBEHI:  tlbehi_q  <= apb_req.pwdata & TLBEHI_MASK;
                REG_TLBELO0: tlbelo0_q <= apb_req.pwdata & TLBELO_MASK;
                REG_TLBELO1: tlbelo1_q <= apb_req.pwdata & TLBELO_MASK;
                REG_TLBIDX:  tlbidx_q  <= apb_req.pwdata & TLBIDX_MASK;
                default:     ;  // command register has no storage
            endcase
        end
    end

    always_comb begin
        rdata = '0;
        if (access && addr_ok) begin
            case (apb_req.paddr)
                REG_CRMD:    rdata = crmd_q;
                REG_ASID:    rdata = asid_q;
                REG_DMW0:    rdata = dmw0_q;
                REG_DMW1:    rdata = dmw1_q;
                REG_TLBEHI:  rdata = tlbehi_q;
                REG_TLBELO0: rdata = tlbelo0_q;
                REG_TLBELO1: rdata = tlbelo1_q;
                REG_TLBIDX:  rdata = tlbidx_q;
                default:     rdata = '0;
            endcase
        end
    end

    assign apb_rsp.prdata  = rdata;
    assign apb_rsp.pready  = 1'b1;  // zero wait states
    assign apb_rsp.pslverr = access & ~addr_ok;

    // entry as it would be written right now
    always_comb begin
        staged.e    = tlbidx_q[31];
        staged.vppn = tlbehi_q[31:13];
        staged.ps   = tlbidx_q[29:24];
        staged.asid = asid_q[9:0];
        staged.g    = tlbelo0_q[6] & tlbelo1_q[6];  // global only if both halves say so
        staged.even = elo_page(tlbelo0_q);
        staged.odd  = elo_page(tlbelo1_q);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_we_q <= 1'b0;
        end else begin
            wr_we_q <= cmd_wr;  // single-cycle pulse
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_wr) begin
            wr_idx_q   <= tlbidx_q[3:0];
            wr_entry_q <= staged;
        end
    end

    assign tlb_wr.we    = wr_we_q;
    assign tlb_wr.index = wr_idx_q;
    assign tlb_wr.entry = wr_entry_q;

    assign cfg.da   = crmd_q[3];
    assign cfg.pg   = crmd_q[4];
    assign cfg.plv  = crmd_q[1:0];
    assign cfg.asid = asid_q[9:0];
    assign cfg.dmw0 = dmw0_q;
    assign cfg.dmw1 = dmw1_q;

    a_penable_needs_psel: assert property (
        @(posedge clk) disable iff (!rst_n) apb_req.penable |-> apb_req.psel
    );

endmodule

// ==== logic/mmu_pkg.sv ====
package mmu_pkg;

    localparam int TLB_ENTRIES = 16;

    // supported page sizes, as log2 of the byte count
    localparam int PS_4K = 12;
    localparam int PS_2M = 21;

    typedef logic [31:0] vaddr_t;
    typedef logic [31:0] paddr_t;
    typedef logic [18:0] vppn_t;  // vaddr[31:13], one even/odd page pair
    typedef logic [19:0] ppn_t;
    typedef logic [9:0]  asid_t;
    typedef logic [1:0]  plv_t;
    typedef logic [1:0]  mat_t;
    typedef logic [3:0]  tlb_idx_t;
    typedef logic [5:0]  ps_t;
    typedef logic [1:0]  access_kind_t;
    typedef logic [2:0]  ecode_t;
    typedef logic [11:0] reg_off_t;

    localparam access_kind_t KIND_FETCH = 2'd0;
    localparam access_kind_t KIND_LOAD  = 2'd1;
    localparam access_kind_t KIND_STORE = 2'd2;

    localparam ecode_t ECODE_NONE = 3'd0;
    localparam ecode_t ECODE_ADE  = 3'd1;
    localparam ecode_t ECODE_TLBR = 3'd2;
    localparam ecode_t ECODE_PIF  = 3'd3;
    localparam ecode_t ECODE_PIL  = 3'd4;
    localparam ecode_t ECODE_PIS  = 3'd5;
    localparam ecode_t ECODE_PPI  = 3'd6;
    localparam ecode_t ECODE_PME  = 3'd7;

    localparam reg_off_t REG_CRMD    = 12'h000;
    localparam reg_off_t REG_ASID    = 12'h004;
    localparam reg_off_t REG_DMW0    = 12'h008;
    localparam reg_off_t REG_DMW1    = 12'h00c;
    localparam reg_off_t REG_TLBEHI  = 12'h010;
    localparam reg_off_t REG_TLBELO0 = 12'h014;
    localparam reg_off_t REG_TLBELO1 = 12'h018;
    localparam reg_off_t REG_TLBIDX  = 12'h01c;
    localparam reg_off_t REG_TLBCMD  = 12'h020;

    // implemented bits of each register, everything else reads 0
    localparam logic [31:0] CRMD_RESET  = 32'h0000_0008;  // da=1
    localparam logic [31:0] CRMD_MASK   = 32'h0000_001b;  // pg, da, plv
    localparam logic [31:0] ASID_MASK   = 32'h0000_03ff;
    localparam logic [31:0] DMW_MASK    = 32'hee00_0039;  // vseg, pseg, mat, plv3, plv0
    localparam logic [31:0] TLBEHI_MASK = 32'hffff_e000;
    localparam logic [31:0] TLBELO_MASK = 32'h0fff_ff7f;
    localparam logic [31:0] TLBIDX_MASK = 32'hbf00_000f;  // e, ps, index

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        reg_off_t    paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    typedef struct packed {
        logic         valid;
        access_kind_t kind;
        vaddr_t       vaddr;
    } xlat_req_t;

    typedef struct packed {
        logic   valid;
        paddr_t paddr;
        mat_t   mat;
        ecode_t ecode;
    } xlat_rsp_t;

    typedef struct packed {
        logic        da;
        logic        pg;
        plv_t        plv;
        asid_t       asid;
        logic [31:0] dmw0;
        logic [31:0] dmw1;
    } mmu_cfg_t;

    typedef struct packed {
        ppn_t ppn;
        plv_t plv;
        mat_t mat;
        logic d;
        logic v;
    } tlb_page_t;

    typedef struct packed {
        logic      e;
        vppn_t     vppn;
        ps_t       ps;
        asid_t     asid;
        logic      g;
        tlb_page_t even;
        tlb_page_t odd;
    } tlb_entry_t;

    typedef struct packed {
        logic       we;
        tlb_idx_t   index;
        tlb_entry_t entry;
    } tlb_wr_t;

    typedef struct packed {
        logic         valid;
        access_kind_t kind;
        vaddr_t       vaddr;
        plv_t         plv;
        logic         bypass;
        paddr_t       bypass_paddr;
        mat_t         bypass_mat;
        logic         ade;
    } xlat_dec_t;

    typedef struct packed {
        xlat_dec_t dec;
        logic      found;
        logic      page_2m;  // selected entry uses 2 MB pages
        tlb_page_t page;
    } tlb_hit_t;

endpackage

// ==== logic/mmu_top.sv ====
`timescale 1ns/10ps

module mmu_top (
    input  logic               clk,
    input  logic               rst_n,
    input  mmu_pkg::apb_req_t  apb_req,
    output mmu_pkg::apb_rsp_t  apb_rsp,
    input  mmu_pkg::xlat_req_t req,
    output mmu_pkg::xlat_rsp_t rsp
);
    import mmu_pkg::*;

    mmu_cfg_t  cfg;
    tlb_wr_t   tlb_wr;
    xlat_dec_t dec;     // decode to execute
    tlb_hit_t  hit;     // execute to result

    mmu_csr_apb u_csr (
        .clk     (clk),
        .rst_n   (rst_n),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp),
        .cfg     (cfg),
        .tlb_wr  (tlb_wr)
    );

    xlat_decode u_decode (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (req),
        .cfg   (cfg),
        .dec   (dec)
    );

    tlb_array u_tlb (
        .clk    (clk),
        .rst_n  (rst_n),
        .tlb_wr (tlb_wr),
        .asid   (cfg.asid),
        .dec    (dec),
        .hit    (hit)
    );

    xlat_result u_result (
        .dec_hit (hit),
        .rsp     (rsp)
    );

endmodule

// ==== logic/tlb_array.sv ====
`timescale 1ns/10ps

module tlb_array (
    input  logic               clk,
    input  logic               rst_n,
    input  mmu_pkg::tlb_wr_t   tlb_wr,
    input  mmu_pkg::asid_t     asid,
    input  mmu_pkg::xlat_dec_t dec,
    output mmu_pkg::tlb_hit_t  hit
);
    import mmu_pkg::*;

    tlb_entry_t             entries [TLB_ENTRIES];
    logic [TLB_ENTRIES-1:0] ent_e;
    logic [TLB_ENTRIES-1:0] is_2m;
    logic [TLB_ENTRIES-1:0] vppn_eq;
    logic [TLB_ENTRIES-1:0] match;

    vppn_t      req_vppn;
    tlb_entry_t sel;
    logic       found;
    logic       sel_2m;
    logic       odd;
    tlb_page_t  page;
    tlb_hit_t   hit_q;
    logic       valid_q;

    // valid bits need reset, entry payload does not
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ent_e <= '0;
        end else if (tlb_wr.we) begin
            ent_e[tlb_wr.index] <= tlb_wr.entry.e;
        end
    end

    always_ff @(posedge clk) begin
        if (tlb_wr.we) begin
            entries[tlb_wr.index] <= tlb_wr.entry;
        end
    end

    assign req_vppn = dec.vaddr[31:13];

    // fully associative compare
    always_comb begin
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            is_2m[i] = (entries[i].ps == ps_t'(PS_2M));
            if (is_2m[i]) begin
                vppn_eq[i] = (entries[i].vppn[18:9] == req_vppn[18:9]);  // vaddr[31:22]
            end else begin
                vppn_eq[i] = (entries[i].vppn == req_vppn);
            end
            match[i] = ent_e[i] && vppn_eq[i] && (entries[i].g || (entries[i].asid == asid));
        end
    end

    always_comb begin
        sel   = '0;
        found = |match;
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            if (match[i]) begin
                sel = entries[i];
            end
        end
        sel_2m = (sel.ps == ps_t'(PS_2M));
        odd    = sel_2m ? dec.vaddr[21] : dec.vaddr[12];  // page-pair select
        page   = odd ? sel.odd : sel.even;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= dec.valid;
        end
    end

    always_ff @(posedge clk) begin
        hit_q.dec     <= dec;
        hit_q.found   <= found;
        hit_q.page_2m <= sel_2m;
        hit_q.page    <= page;
    end

    always_comb begin
        hit           = hit_q;
        hit.dec.valid = valid_q;
    end

    // software must never stage overlapping entries
    a_single_match: assert property (
        @(posedge clk) disable iff (!rst_n)
        (dec.valid && !dec.bypass) |-> $onehot0(match)
    );

endmodule

// ==== logic/xlat_decode.sv ====
`timescale 1ns/10ps

module xlat_decode (
    input  logic               clk,
    input  logic               rst_n,
    input  mmu_pkg::xlat_req_t req,
    input  mmu_pkg::mmu_cfg_t  cfg,
    output mmu_pkg::xlat_dec_t dec
);
    import mmu_pkg::*;

    logic      hit0;
    logic      hit1;
    xlat_dec_t nxt;
    xlat_dec_t dec_q;
    logic      valid_q;

    // window enabled for this plv and segment matches
    function automatic logic dmw_hit(input logic [31:0] dmw, input plv_t plv,
                                     input logic [2:0] vseg);
        logic en;
        en = (plv == 2'd0) ? dmw[0] : ((plv == 2'd3) ? dmw[3] : 1'b0);
        return en && (dmw[31:29] == vseg);
    endfunction

    always_comb begin
        hit0 = dmw_hit(cfg.dmw0, cfg.plv, req.vaddr[31:29]);
        hit1 = dmw_hit(cfg.dmw1, cfg.plv, req.vaddr[31:29]);

        nxt       = '0;
        nxt.valid = req.valid;
        nxt.kind  = req.kind;
        nxt.vaddr = req.vaddr;
        nxt.plv   = cfg.plv;

        if (cfg.da) begin
            nxt.bypass       = 1'b1;  // direct mode, identity mapping
            nxt.bypass_paddr = req.vaddr;
            nxt.bypass_mat   = '0;
        end else if (hit0) begin
            nxt.bypass       = 1'b1;
            nxt.bypass_paddr = {cfg.dmw0[27:25], req.vaddr[28:0]};
            nxt.bypass_mat   = cfg.dmw0[5:4];
        end else if (hit1) begin
            nxt.bypass       = 1'b1;
            nxt.bypass_paddr = {cfg.dmw1[27:25], req.vaddr[28:0]};
            nxt.bypass_mat   = cfg.dmw1[5:4];
        end else begin
            // user mode may not touch the upper half unless a window covers it
            nxt.ade = (cfg.plv == 2'd3) && req.vaddr[31];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= req.valid;
        end
    end

    always_ff @(posedge clk) begin
        dec_q <= nxt;
    end

    always_comb begin
        dec       = dec_q;
        dec.valid = valid_q;
    end

endmodule

// ==== logic/xlat_result.sv ====
`timescale 1ns/10ps

module xlat_result (
    input  mmu_pkg::tlb_hit_t  dec_hit,
    output mmu_pkg::xlat_rsp_t rsp
);
    import mmu_pkg::*;

    ecode_t code;
    paddr_t page_pa;

    always_comb begin
        if (dec_hit.page_2m) begin
            page_pa = {dec_hit.page.ppn[19:9], dec_hit.dec.vaddr[20:0]};
        end else begin
            page_pa = {dec_hit.page.ppn, dec_hit.dec.vaddr[11:0]};
        end
    end

    // first matching check wins
    always_comb begin
        if (dec_hit.dec.bypass) begin
            code = ECODE_NONE;
        end else if (dec_hit.dec.ade) begin
            code = ECODE_ADE;
        end else if (!dec_hit.found) begin
            code = ECODE_TLBR;
        end else if (!dec_hit.page.v) begin
            case (dec_hit.dec.kind)
                KIND_FETCH: code = ECODE_PIF;
                KIND_LOAD:  code = ECODE_PIL;
                default:    code = ECODE_PIS;
            endcase
        end else if (dec_hit.dec.plv > dec_hit.page.plv) begin
            code = ECODE_PPI;
        end else if ((dec_hit.dec.kind == KIND_STORE) && !dec_hit.page.d) begin
            code = ECODE_PME;  // first write to a clean page
        end else begin
            code = ECODE_NONE;
        end
    end

    always_comb begin
        rsp.valid = dec_hit.dec.valid;
        rsp.ecode = code;
        if (code != ECODE_NONE) begin
            rsp.paddr = '0;
            rsp.mat   = '0;
        end else if (dec_hit.dec.bypass) begin
            rsp.paddr = dec_hit.dec.bypass_paddr;
            rsp.mat   = dec_hit.dec.bypass_mat;
        end else begin
            rsp.paddr = page_pa;
            rsp.mat   = dec_hit.page.mat;
        end
    end

    // decode raises ade only on the mapped path
    a_ade_not_bypassed: assert final (
        !(dec_hit.dec.valid && dec_hit.dec.bypass && dec_hit.dec.ade)
    );

endmodule

// ==== verification/mmu_tb.sv ====
`timescale 1ns/10ps

module mmu_tb;
    import mmu_pkg::*;

    // cycles used by the sequence below with reset included
    localparam int STIM_CYCLES = 322;
    localparam int CYCLE_LIMIT = 2 * STIM_CYCLES;

    // implemented register bits per field layout
    localparam logic [31:0] CRMD_BITS   = 32'h0000_001b;
    localparam logic [31:0] ASID_BITS   = 32'h0000_03ff;
    localparam logic [31:0] DMW_BITS    = 32'hee00_0039;
    localparam logic [31:0] EHI_BITS    = 32'hffff_e000;
    localparam logic [31:0] ELO_BITS    = 32'h0fff_ff7f;
    localparam logic [31:0] IDX_BITS    = 32'hbf00_000f;

    logic      clk;
    logic      rst_n;
    apb_req_t  apb_req;
    apb_rsp_t  apb_rsp;
    xlat_req_t req;
    xlat_rsp_t rsp;

    xlat_rsp_t exp_in;  // expectation for the request on the bus now
    xlat_rsp_t exp_d1;
    xlat_rsp_t exp_d2;  // lines up with rsp

    logic        apb_chk;
    logic        apb_chk_rd;
    logic        apb_exp_err;
    logic [31:0] apb_exp_data;

    int xlat_errs;
    int apb_errs;
    int req_cnt;
    int apb_cnt;
    int cycle_cnt;
    logic [31:0] lfsr_state;

    // register and TLB mirror
    logic [31:0] m_crmd;
    logic [31:0] m_asid;
    logic [31:0] m_dmw0;
    logic [31:0] m_dmw1;
    logic [31:0] m_ehi;
    logic [31:0] m_elo0;
    logic [31:0] m_elo1;
    logic [31:0] m_idx;
    logic        m_tlb_e    [TLB_ENTRIES];
    logic [18:0] m_tlb_vppn [TLB_ENTRIES];
    logic [5:0]  m_tlb_ps   [TLB_ENTRIES];
    logic [9:0]  m_tlb_asid [TLB_ENTRIES];
    logic        m_tlb_g    [TLB_ENTRIES];
    logic [31:0] m_tlb_lo0  [TLB_ENTRIES];
    logic [31:0] m_tlb_lo1  [TLB_ENTRIES];

    mmu_top u_mmu_top (
        .clk     (clk),
        .rst_n   (rst_n),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp),
        .req     (req),
        .rsp     (rsp)
    );

    always #5 clk = ~clk;

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exp_d1 <= '0;
            exp_d2 <= '0;
        end else begin
            exp_d1 <= exp_in;
            exp_d2 <= exp_d1;  // two-cycle latency
        end
    end

    chk_rsp_valid: assert property (@(posedge clk) disable iff (!rst_n)
        rsp.valid == exp_d2.valid)
    else begin
        xlat_errs++;
        $display("[FAIL] %0t rsp.valid expected %0b got %0b", $time,
                 $sampled(exp_d2.valid), $sampled(rsp.valid));
    end

    chk_rsp_paddr: assert property (@(posedge clk) disable iff (!rst_n)
        exp_d2.valid |-> rsp.paddr == exp_d2.paddr)
    else begin
        xlat_errs++;
        $display("[FAIL] %0t rsp.paddr expected %h got %h", $time,
                 $sampled(exp_d2.paddr), $sampled(rsp.paddr));
    end

    chk_rsp_mat: assert property (@(posedge clk) disable iff (!rst_n)
        exp_d2.valid |-> rsp.mat == exp_d2.mat)
    else begin
        xlat_errs++;
        $display("[FAIL] %0t rsp.mat expected %0d got %0d", $time,
                 $sampled(exp_d2.mat), $sampled(rsp.mat));
    end

    chk_rsp_ecode: assert property (@(posedge clk) disable iff (!rst_n)
        exp_d2.valid |-> rsp.ecode == exp_d2.ecode)
    else begin
        xlat_errs++;
        $display("[FAIL] %0t rsp.ecode expected %0d got %0d", $time,
                 $sampled(exp_d2.ecode), $sampled(rsp.ecode));
    end

    chk_pready: assert property (@(posedge clk) disable iff (!rst_n)
        apb_chk |-> apb_rsp.pready)
    else begin
        apb_errs++;
        $display("[FAIL] %0t apb_rsp.pready expected 1 got 0", $time);
    end

    chk_pslverr: assert property (@(posedge clk) disable iff (!rst_n)
        apb_chk |-> apb_rsp.pslverr == apb_exp_err)
    else begin
        apb_errs++;
        $display("[FAIL] %0t apb_rsp.pslverr expected %0b got %0b", $time,
                 $sampled(apb_exp_err), $sampled(apb_rsp.pslverr));
    end

    chk_prdata: assert property (@(posedge clk) disable iff (!rst_n)
        apb_chk_rd |-> apb_rsp.prdata == apb_exp_data)
    else begin
        apb_errs++;
        $display("[FAIL] %0t apb_rsp.prdata expected %h got %h", $time,
                 $sampled(apb_exp_data), $sampled(apb_rsp.prdata));
    end

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_bit()};
        end
        return v;
    endfunction

    function automatic logic off_valid(input reg_off_t addr);
        return (addr[1:0] == 2'b00) && (addr <= 12'h020);
    endfunction

    function automatic logic [31:0] mirror_read(input reg_off_t addr);
        case (addr)
            REG_CRMD:    return m_crmd;
            REG_ASID:    return m_asid;
            REG_DMW0:    return m_dmw0;
            REG_DMW1:    return m_dmw1;
            REG_TLBEHI:  return m_ehi;
            REG_TLBELO0: return m_elo0;
            REG_TLBELO1: return m_elo1;
            REG_TLBIDX:  return m_idx;
            default:     return 32'h0;  // command register and holes
        endcase
    endfunction

    function automatic logic window_covers(input logic [31:0] w, input logic [31:0] va);
        logic en;
        en = 1'b0;
        if (m_crmd[1:0] == 2'd0) en = w[0];
        if (m_crmd[1:0] == 2'd3) en = w[3];
        return en && (w[31:29] == va[31:29]);
    endfunction

    // reference translation from the mirror
    function automatic xlat_rsp_t expect_xlat(input access_kind_t kind, input logic [31:0] va);
        xlat_rsp_t   r;
        logic [1:0]  plv;
        logic [31:0] lo;
        logic        big;
        int          idx;
        r       = '0;
        r.valid = 1'b1;
        plv     = m_crmd[1:0];
        idx     = -1;
        if (m_crmd[3]) begin
            r.paddr = va;
            return r;
        end
        if (window_covers(m_dmw0, va)) begin
            r.paddr = {m_dmw0[27:25], va[28:0]};
            r.mat   = m_dmw0[5:4];
            return r;
        end
        if (window_covers(m_dmw1, va)) begin
            r.paddr = {m_dmw1[27:25], va[28:0]};
            r.mat   = m_dmw1[5:4];
            return r;
        end
        if (plv == 2'd3 && va[31]) begin
            r.ecode = ECODE_ADE;
            return r;
        end
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            if (m_tlb_e[i] && (m_tlb_g[i] || m_tlb_asid[i] == m_asid[9:0]) &&
                ((m_tlb_ps[i] == 6'd21) ? (m_tlb_vppn[i][18:9] == va[31:22])
                                        : (m_tlb_vppn[i] == va[31:13]))) begin
                idx = i;
            end
        end
        if (idx < 0) begin
            r.ecode = ECODE_TLBR;
            return r;
        end
        big = (m_tlb_ps[idx] == 6'd21);
        lo  = (big ? va[21] : va[12]) ? m_tlb_lo1[idx] : m_tlb_lo0[idx];
        if (!lo[0]) begin
            r.ecode = (kind == KIND_FETCH) ? ECODE_PIF :
                      (kind == KIND_LOAD)  ? ECODE_PIL : ECODE_PIS;
        end else if (plv > lo[3:2]) begin
            r.ecode = ECODE_PPI;
        end else if (kind == KIND_STORE && !lo[1]) begin
            r.ecode = ECODE_PME;
        end else begin
            r.paddr = big ? {lo[27:17], va[20:0]} : {lo[27:8], va[11:0]};
            r.mat   = lo[5:4];
        end
        return r;
    endfunction

    task automatic mirror_write(input reg_off_t addr, input logic [31:0] data);
        int i;
        i = int'(m_idx[3:0]);
        case (addr)
            REG_CRMD:    m_crmd = data & CRMD_BITS;
            REG_ASID:    m_asid = data & ASID_BITS;
            REG_DMW0:    m_dmw0 = data & DMW_BITS;
            REG_DMW1:    m_dmw1 = data & DMW_BITS;
            REG_TLBEHI:  m_ehi  = data & EHI_BITS;
            REG_TLBELO0: m_elo0 = data & ELO_BITS;
            REG_TLBELO1: m_elo1 = data & ELO_BITS;
            REG_TLBIDX:  m_idx  = data & IDX_BITS;
            default: begin  // command stages into the indexed entry
                m_tlb_e[i]    = m_idx[31];
                m_tlb_vppn[i] = m_ehi[31:13];
                m_tlb_ps[i]   = m_idx[29:24];
                m_tlb_asid[i] = m_asid[9:0];
                m_tlb_g[i]    = m_elo0[6] & m_elo1[6];
                m_tlb_lo0[i]  = m_elo0;
                m_tlb_lo1[i]  = m_elo1;
            end
        endcase
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic apb_write(input reg_off_t addr, input logic [31:0] data);
        apb_req.psel    = 1'b1;  // setup phase
        apb_req.penable = 1'b0;
        apb_req.pwrite  = 1'b1;
        apb_req.paddr   = addr;
        apb_req.pwdata  = data;
        next_cycle();
        apb_req.penable = 1'b1;
        apb_exp_err     = !off_valid(addr);
        apb_chk         = 1'b1;
        next_cycle();
        apb_req.psel    = 1'b0;
        apb_req.penable = 1'b0;
        apb_chk         = 1'b0;
        apb_cnt++;
        if (off_valid(addr)) begin
            mirror_write(addr, data);
        end
    endtask

    task automatic apb_read(input reg_off_t addr);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = 1'b0;
        apb_req.paddr   = addr;
        next_cycle();
        apb_req.penable = 1'b1;
        apb_exp_err     = !off_valid(addr);
        apb_exp_data    = mirror_read(addr);
        apb_chk         = 1'b1;
        apb_chk_rd      = 1'b1;
        next_cycle();
        apb_req.psel    = 1'b0;
        apb_req.penable = 1'b0;
        apb_chk         = 1'b0;
        apb_chk_rd      = 1'b0;
        apb_cnt++;
    endtask

    task automatic write_readback(input reg_off_t addr, input logic [31:0] data);
        apb_write(addr, data);
        apb_read(addr);
    endtask

    // stage one valid entry and commit it
    task automatic load_entry(input int idx, input logic [31:0] ehi, input logic [31:0] lo0,
                              input logic [31:0] lo1, input int ps);
        apb_write(REG_TLBEHI, ehi);
        apb_write(REG_TLBELO0, lo0);
        apb_write(REG_TLBELO1, lo1);
        apb_write(REG_TLBIDX, 32'h8000_0000 | (32'(ps) << 24) | 32'(idx));
        apb_write(REG_TLBCMD, 32'h1);
    endtask

    task automatic send(input access_kind_t kind, input logic [31:0] va);
        req.valid = 1'b1;
        req.kind  = kind;
        req.vaddr = va;
        exp_in    = expect_xlat(kind, va);
        req_cnt++;
        next_cycle();
    endtask

    task automatic drain();
        req.valid = 1'b0;
        exp_in    = '0;
        repeat (2) next_cycle();
    endtask

    // back-to-back requests with random offsets and kinds
    task automatic send_burst(input logic [31:0] base, input logic [31:0] mask, input int n);
        logic [1:0] k;
        for (int i = 0; i < n; i++) begin
            k = 2'(rand_bits(2));
            send((k == 2'd3) ? KIND_LOAD : access_kind_t'(k), base | (rand_bits(32) & mask));
        end
        drain();
    endtask

    task automatic report_and_finish(input bit timed_out);
        $display("requests %0d, apb transfers %0d, xlat errors %0d, apb errors %0d",
                 req_cnt, apb_cnt, xlat_errs, apb_errs);
        if (!timed_out && xlat_errs == 0 && apb_errs == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    endtask

    initial begin
        cycle_cnt = 0;
        wait (rst_n === 1'b0);
        while (cycle_cnt < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        report_and_finish(1'b1);
    end

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        apb_req = '0;
        req = '0;
        exp_in = '0;
        apb_chk = 1'b0;
        apb_chk_rd = 1'b0;
        apb_exp_err = 1'b0;
        apb_exp_data = '0;
        xlat_errs = 0;
        apb_errs = 0;
        req_cnt = 0;
        apb_cnt = 0;
        lfsr_state = 32'hb18c;
        m_crmd = 32'h8;  // da after reset
        {m_asid, m_dmw0, m_dmw1, m_ehi, m_elo0, m_elo1, m_idx} = '0;
        for (int i = 0; i < TLB_ENTRIES; i++) m_tlb_e[i] = 1'b0;
        repeat (3) @(posedge clk);
        #1 rst_n = 1'b1;

        // reset values in direct mode
        for (int a = 0; a <= 32; a += 4) apb_read(reg_off_t'(a));
        send_burst(32'h0, 32'hffff_ffff, 24);

        write_readback(REG_CRMD, 32'hffff_ffef);  // da stays set with plv 3
        write_readback(REG_ASID, 32'h1234_5678);
        write_readback(REG_DMW0, 32'h5a5a_5a5a);
        write_readback(REG_DMW1, 32'ha5a5_a5a5);
        write_readback(REG_TLBEHI, 32'hdead_beef);
        write_readback(REG_TLBELO0, 32'hffff_ffff);
        write_readback(REG_TLBELO1, 32'h1357_9bdf);
        write_readback(REG_TLBIDX, 32'hffff_ffff);
        apb_read(REG_TLBCMD);
        apb_write(12'h024, 32'hffff_ffff);
        apb_read(12'h024);
        apb_write(12'h001, 32'h0);  // unaligned so crmd is untouched
        apb_read(12'h00a);
        apb_read(REG_CRMD);
        send_burst(32'h0, 32'hffff_ffff, 8);

        // direct windows
        apb_write(REG_DMW0, 32'ha000_0011);  // vseg 5 pseg 0 mat 1 plv0
        apb_write(REG_DMW1, 32'h8200_0021);  // vseg 4 pseg 1 mat 2 plv0
        apb_write(REG_CRMD, 32'h10);
        send_burst(32'ha000_0000, 32'h1fff_ffff, 8);
        send_burst(32'h8000_0000, 32'h1fff_ffff, 8);
        apb_write(REG_DMW1, 32'hae00_0039);  // overlaps dmw0
        send_burst(32'ha000_0000, 32'h1fff_ffff, 6);
        apb_write(REG_DMW1, 32'hc200_0029);  // vseg 6 with plv3 allowed
        apb_write(REG_CRMD, 32'h13);
        send_burst(32'ha000_0000, 32'h1fff_ffff, 4);
        send_burst(32'h0, 32'hffff_ffff, 12);

        // tlb lookups
        apb_write(REG_CRMD, 32'h10);
        apb_write(REG_DMW0, 32'h0);
        apb_write(REG_DMW1, 32'h0);
        apb_write(REG_ASID, 32'h12);
        load_entry(0, 32'h0040_0000, 32'h0123_4513, 32'h00ab_cd2f, PS_4K);
        send_burst(32'h0040_0000, 32'h0000_1fff, 10);
        load_entry(1, 32'h1000_0000, 32'h0400_0013, 32'h0402_0033, PS_2M);
        send_burst(32'h1000_0000, 32'h003f_ffff, 10);
        apb_write(REG_ASID, 32'h55);
        load_entry(2, 32'h0080_0000, 32'h0055_5513, 32'h0066_6613, PS_4K);
        load_entry(3, 32'h00c0_0000, 32'h0077_7753, 32'h0088_8853, PS_4K);  // global
        apb_write(REG_ASID, 32'h12);
        send_burst(32'h0080_0000, 32'h0000_1fff, 4);
        send_burst(32'h00c0_0000, 32'h0000_1fff, 4);
        apb_write(REG_ASID, 32'h55);
        send_burst(32'h0080_0000, 32'h0000_1fff, 4);
        apb_write(REG_ASID, 32'h12);
        load_entry(2, 32'h0080_0000, 32'h0099_9913, 32'h00aa_aa13, PS_4K);
        send_burst(32'h0080_0000, 32'h0000_1fff, 4);
        load_entry(0, 32'h0200_0000, 32'h0bbb_bb13, 32'h0ccc_cc2f, PS_4K);
        send_burst(32'h0040_0000, 32'h0000_1fff, 2);
        send_burst(32'h0200_0000, 32'h0000_1fff, 3);

        // exception priority
        load_entry(4, 32'h0300_0000, 32'h0111_1102, 32'h0222_2211, PS_4K);
        send(KIND_FETCH, 32'h0300_0abc);
        send(KIND_LOAD, 32'h0300_0123);
        send(KIND_STORE, 32'h0300_0ff0);
        send(KIND_STORE, 32'h0300_1004);  // clean page
        send(KIND_LOAD, 32'h0300_1008);
        drain();
        apb_write(REG_CRMD, 32'h13);
        send(KIND_LOAD, 32'h0300_1010);
        send(KIND_STORE, 32'h0300_1014);
        send(KIND_STORE, 32'h0300_0010);
        send(KIND_LOAD, 32'h0200_1000);
        send(KIND_STORE, 32'h0200_1004);
        send(KIND_LOAD, 32'h9000_0000);
        send(KIND_FETCH, 32'h0500_0000);
        drain();
        report_and_finish(1'b0);
    end

endmodule
